/* compile.f */
verilog/stepper_pkg.sv
verilog/spi_word_receiver.sv
verilog/command_decoder.sv
verilog/move_buffer.sv
verilog/dda_step_generator.sv
verilog/hbridge_sequencer.sv
verilog/quadrature_counter.sv
verilog/stepper_top.sv
tb/stepper_checker.sv
tb/stepper_tb.sv

/* tb/stepper_checker.sv */
`timescale 1ns/1ps

module stepper_checker (
  input logic CLK,
  input logic reset,
  input logic word_valid,
  input logic step,
  input logic dir,
  input logic busy,
  input logic overflow,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);

  // Set by the first decoded SPI word
  logic cmd_seen;
  // Failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      cmd_seen <= 1'b0;
    end else if (word_valid) begin
      cmd_seen <= 1'b1;
    end
  end

  // Step is a single-cycle pulse
  step_pulse: assert property (@(posedge CLK) disable iff (reset) step |=> !step)
    else begin
      $error("step stayed high for more than one cycle");
      fail_count++;
    end

  // Nothing moves before the host has sent a word
  quiet_after_reset: assert property (@(posedge CLK) disable iff (reset)
    !cmd_seen |-> (!step && !busy && !overflow))
    else begin
      $error("step, busy or overflow active before any command");
      fail_count++;
    end

  // Both legs of one coil never driven together
  coil_legs: assert property (@(posedge CLK) disable iff (reset)
    !(phase_a1 && phase_a2) && !(phase_b1 && phase_b2))
    else begin
      $error("both legs of one H-bridge phase driven high");
      fail_count++;
    end

  // Direction settled around a step
  dir_stable: assert property (@(posedge CLK) disable iff (reset) step |-> $stable(dir))
    else begin
      $error("dir changed while step was high");
      fail_count++;
    end

endmodule

bind stepper_top stepper_checker checks (
  .CLK(CLK), .reset(reset), .word_valid(word_valid), .step(step), .dir(dir),
  .busy(busy), .overflow(overflow), .phase_a1(phase_a1), .phase_a2(phase_a2),
  .phase_b1(phase_b1), .phase_b2(phase_b2)
);

/* tb/stepper_tb.sv */
`timescale 1ns/1ps

module stepper_tb import stepper_pkg::*; ();

  // 16 CLK cycles per SCK period
  localparam int HALF_SCK = 8;
  localparam logic signed [63:0] MODEL_THRESHOLD = 64'sh7fffffffffffff9b;

  logic CLK;
  logic reset;
  logic sck;
  logic cs_n;
  logic copi;
  logic enc_a;
  logic enc_b;
  wire  cipo;
  wire  phase_a1;
  wire  phase_a2;
  wire  phase_b1;
  wire  phase_b2;
  wire  step;
  wire  dir;
  wire  busy;
  wire  overflow;

  logic [31:0]        lfsr_state = 32'h43fbbadf;
  int                 value_errors = 0;
  int                 timeout_errors = 0;
  // Monitor counts, updated on the rising edge only
  int                 step_count = 0;
  int                 busy_falls = 0;
  logic               busy_prev = 1'b0;
  // Reference state
  logic signed [63:0] model_acc = '0;
  logic signed [63:0] enc_expected = '0;
  logic [1:0]         enc_phase = 2'd0;
  int                 phase_index = 0;
  logic               half_step_mode = 1'b0;

  stepper_top uut (
    .CLK(CLK), .reset(reset), .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2), .step(step), .dir(dir),
    .busy(busy), .overflow(overflow)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Pre-edge values, no race with the stimulus on the falling edge
  always @(posedge CLK) begin
    if (!reset) begin
      if (step) step_count <= step_count + 1;
      if (busy_prev && !busy) busy_falls <= busy_falls + 1;
      busy_prev <= busy;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic cmd_word_u header_word(input logic [7:0] op, input logic [55:0] payload);
    cmd_word_u w;
    w.hdr.opcode  = op;
    w.hdr.payload = payload;
    return w;
  endfunction

  function automatic cmd_word_u data_word(input logic signed [63:0] value);
    cmd_word_u w;
    w.data = value;
    return w;
  endfunction

  // Two-phase drive table {a1, a2, b1, b2}
  function automatic logic [3:0] coil_pattern(input int idx);
    case (idx)
      0:       return 4'b1000;
      1:       return 4'b1010;
      2:       return 4'b0010;
      3:       return 4'b0110;
      4:       return 4'b0100;
      5:       return 4'b0101;
      6:       return 4'b0001;
      default: return 4'b1001;
    endcase
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    assert (got === exp) else begin
      value_errors++;
      $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  // Mode 0 frame, MSB first, reply sampled as SCK rises
  task automatic spi_transfer(input logic [63:0] tx, output logic [63:0] rx);
    int  i;
    int  n;
    bit  seen;
    rx   = '0;
    cs_n = 1'b0;
    for (i = 63; i >= 0; i--) begin
      copi = tx[i];
      wait_cycles(HALF_SCK);
      sck = 1'b1;
      rx  = {rx[62:0], cipo};
      wait_cycles(HALF_SCK);
      sck = 1'b0;
    end
    wait_cycles(HALF_SCK);
    cs_n = 1'b1;
    seen = 1'b0;
    for (n = 0; n < 32 && !seen; n++) begin
      @(negedge CLK);
      if (uut.word_valid) seen = 1'b1;
    end
    if (!seen) begin
      timeout_errors++;
      $display("Timeout at %0t: no word strobe after an SPI frame", $time);
    end
    wait_cycles(2);
  endtask

  task automatic wait_moves(input int target, input int limit);
    int n;
    for (n = 0; n < limit && busy_falls < target; n++) @(negedge CLK);
    if (busy_falls < target) begin
      timeout_errors++;
      $display("Timeout at %0t: move %0d never finished", $time, target);
    end
  endtask

  // Gray sequence 00, 10, 11, 01 counts up
  task automatic step_encoder(input logic up);
    enc_phase = up ? enc_phase + 2'd1 : enc_phase - 2'd1;
    case (enc_phase)
      2'd0:    {enc_a, enc_b} = 2'b00;
      2'd1:    {enc_a, enc_b} = 2'b10;
      2'd2:    {enc_a, enc_b} = 2'b11;
      default: {enc_a, enc_b} = 2'b01;
    endcase
    enc_expected = enc_expected + (up ? 64'sd1 : -64'sd1);
    wait_cycles(4);
  endtask

  // Reference DDA, accumulator kept across moves
  task automatic model_move(input int dur, input logic signed [63:0] inc,
                            input logic signed [63:0] incinc, output int steps);
    logic signed [63:0] rate;
    logic signed [63:0] sum;
    int t;
    steps = 0;
    rate  = '0;
    for (t = 0; t < dur; t++) begin
      rate = (t == 0) ? inc : rate + incinc;
      sum  = model_acc + rate;
      if (sum > 0) begin
        steps++;
        model_acc = sum - MODEL_THRESHOLD;
      end else begin
        model_acc = sum;
      end
    end
  endtask

  task automatic queue_move(input logic mdir, input int dur, input logic signed [63:0] inc,
                            input logic signed [63:0] incinc);
    logic [63:0] reply;
    spi_transfer(header_word(OP_MOVE, {55'd0, mdir}), reply);
    spi_transfer(data_word(64'(dur)), reply);
    spi_transfer(data_word(inc), reply);
    spi_transfer(data_word(incinc), reply);
  endtask

  // Move at the current divisor, then steps, dir and coils
  task automatic run_checked_move(input logic mdir, input int dur,
                                  input logic signed [63:0] inc,
                                  input logic signed [63:0] incinc);
    int steps_exp;
    int steps_start;
    int falls_start;
    int steps_got;
    int delta;
    steps_start = step_count;
    falls_start = busy_falls;
    model_move(dur, inc, incinc, steps_exp);
    queue_move(mdir, dur, inc, incinc);
    wait_moves(falls_start + 1, 2000);
    // Last step and coil update settle
    wait_cycles(4);
    steps_got = step_count - steps_start;
    check_value(steps_got, steps_exp, "step count");
    check_value(dir, mdir, "dir level");
    delta = half_step_mode ? 1 : 2;
    phase_index = ((phase_index + (mdir ? 1 : -1) * steps_got * delta) % 8 + 8) % 8;
    check_value({phase_a1, phase_a2, phase_b1, phase_b2}, coil_pattern(phase_index),
                "coil phases");
  endtask

  initial begin
    logic [63:0]        reply;
    logic               mdir;
    int                 dur;
    logic signed [63:0] inc;
    logic signed [63:0] incinc;
    int                 i;
    int                 n;
    int                 s;
    int                 steps_exp;
    int                 steps_start;
    int                 falls_start;
    reset = 1'b1;
    sck   = 1'b0;
    cs_n  = 1'b1;
    copi  = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    wait_cycles(4);
    reset = 1'b0;
    wait_cycles(4);

    // Version answers on the filler word
    spi_transfer(header_word(OP_VERSION, 56'd0), reply);
    spi_transfer(64'd0, reply);
    check_value(reply, 64'h0000_0000_0001_0203, "version reply");

    // Random walk on the encoder
    n = 8 + int'(random_bits(5));
    for (i = 0; i < n; i++) begin
      step_encoder(random_bits(1) != 0);
    end
    // Reply lags one frame
    spi_transfer(64'd0, reply);
    spi_transfer(64'd0, reply);
    check_value(reply, enc_expected, "encoder count reply");

    // Divisor 4, one full-step move then two half-step moves
    spi_transfer(header_word(OP_DIVISOR, 56'd4), reply);
    for (i = 0; i < 3; i++) begin
      if (i == 1) begin
        spi_transfer(header_word(OP_MICROSTEP, 56'd1), reply);
        half_step_mode = 1'b1;
      end
      mdir   = random_bits(1) != 0;
      dur    = 16 + int'(random_bits(4));
      inc    = random_bits(62);
      incinc = random_bits(40);
      run_checked_move(mdir, dur, inc, incinc);
    end

    // Long moves: one runs, four wait, the sixth is dropped
    spi_transfer(header_word(OP_DIVISOR, 56'd40), reply);
    falls_start = busy_falls;
    steps_start = step_count;
    steps_exp   = 0;
    for (i = 0; i < 6; i++) begin
      if (i == 5) begin
        check_value(overflow, 1'b0, "overflow before buffer is full");
      end else begin
        model_move(800, 64'sd0, 64'sd0, s);
        steps_exp += s;
      end
      queue_move(i[0], 800, 64'sd0, 64'sd0);
    end
    for (n = 0; n < 16 && !overflow; n++) @(negedge CLK);
    check_value(overflow, 1'b1, "overflow after sixth move");
    for (i = 1; i <= 5; i++) begin
      wait_moves(falls_start + i, 40000);
    end
    // A stray sixth move would have loaded by now
    wait_cycles(100);
    check_value(busy_falls - falls_start, 5, "completed long moves");
    check_value(busy, 1'b0, "busy after the last move");
    check_value(step_count - steps_start, steps_exp, "steps in long moves");
    check_value(dir, 1'b0, "dir after long moves");

    $display("Errors: %0d value, %0d timeout, %0d assertion",
             value_errors, timeout_errors, uut.checks.fail_count);
    if (value_errors == 0 && timeout_errors == 0 && uut.checks.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog/command_decoder.sv */
`timescale 1ns/1ps

module command_decoder import stepper_pkg::*; (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     word_valid,
  input  logic [WORD_W-1:0]        word_data,
  input  logic signed [WORD_W-1:0] encoder_count,
  input  logic signed [WORD_W-1:0] encoder_count_last,
  output logic [WORD_W-1:0]        reply_word,
  output logic [DIV_W-1:0]         clock_divisor,
  output logic                     half_step,
  output logic                     push_valid,
  output logic                     push_dir,
  output logic [WORD_W-1:0]        push_duration,
  output logic signed [WORD_W-1:0] push_increment,
  output logic signed [WORD_W-1:0] push_incr_incr,
  input  logic                     push_ready,
  output logic                     overflow
);

  cmd_word_u  cmd;
  // Data words still expected after a header
  logic [1:0] words_left;
  // Set while the pending data words belong to a move
  logic       in_move;

  assign cmd = word_data;

  always_ff @(posedge CLK) begin
    if (reset) begin
      words_left    <= 2'd0;
      in_move       <= 1'b0;
      clock_divisor <= DEFAULT_DIVISOR;
      half_step     <= 1'b0;
      push_valid    <= 1'b0;
      overflow      <= 1'b0;
      reply_word    <= '0;
    end else begin
      push_valid <= 1'b0;
      // Full buffer drops the move, flag is sticky
      if (push_valid && !push_ready) begin
        overflow <= 1'b1;
      end
      if (word_valid) begin
        // Encoder count unless overridden below
        reply_word <= encoder_count;
        if (words_left == 2'd0) begin
          case (cmd.hdr.opcode)
            OP_MOVE: begin
              words_left <= 2'd3;
              in_move    <= 1'b1;
            end
            OP_DIVISOR:   clock_divisor <= cmd.hdr.payload[DIV_W-1:0];
            OP_MICROSTEP: half_step     <= cmd.hdr.payload[0];
            OP_VERSION: begin
              // One filler word follows
              words_left <= 2'd1;
              in_move    <= 1'b0;
              reply_word <= {{(WORD_W-24){1'b0}}, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: ;
          endcase
        end else begin
          words_left <= words_left - 2'd1;
          // Increment word answers with count at last tick
          if (in_move && words_left == 2'd2) begin
            reply_word <= encoder_count_last;
          end
          if (in_move && words_left == 2'd1) begin
            push_valid <= 1'b1;
          end
        end
      end
    end
  end

  // Move record assembly
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (words_left == 2'd0 && cmd.hdr.opcode == OP_MOVE) begin
        push_dir <= cmd.hdr.payload[0];
      end
      if (in_move) begin
        case (words_left)
          2'd3:    push_duration  <= cmd.data;
          2'd2:    push_increment <= cmd.data;
          2'd1:    push_incr_incr <= cmd.data;
          default: ;
        endcase
      end
    end
  end

endmodule

/* verilog/dda_step_generator.sv */
`timescale 1ns/1ps

module dda_step_generator import stepper_pkg::*; (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic [DIV_W-1:0]         clock_divisor,
  input  logic                     move_valid,
  input  logic                     move_dir,
  input  logic [WORD_W-1:0]        move_duration,
  input  logic signed [WORD_W-1:0] move_increment,
  input  logic signed [WORD_W-1:0] move_incr_incr,
  output logic                     move_ready,
  output logic                     step,
  output logic                     dir,
  output logic                     busy,
  input  logic signed [WORD_W-1:0] encoder_count,
  output logic signed [WORD_W-1:0] encoder_count_last
);

  logic [DIV_W-1:0]         div_cnt;
  // Ticks remaining in the current move
  logic [WORD_W-1:0]        ticks_left;
  logic                     first_tick;
  logic signed [WORD_W-1:0] rate;
  logic signed [WORD_W-1:0] accum;
  logic signed [WORD_W-1:0] inc_r;
  logic signed [WORD_W-1:0] incinc_r;
  logic signed [WORD_W-1:0] rate_next;
  logic signed [WORD_W-1:0] acc_sum;
  logic                     load;
  logic                     tick;

  assign move_ready = ~busy;
  assign load       = move_valid & move_ready;
  assign tick       = busy && (div_cnt == clock_divisor - 1'b1);

  // Rate ramps by incr_incr after the first tick
  assign rate_next = first_tick ? inc_r : rate + incinc_r;
  assign acc_sum   = accum + rate_next;

  always_ff @(posedge CLK) begin
    if (reset) begin
      busy               <= 1'b0;
      div_cnt            <= '0;
      ticks_left         <= '0;
      first_tick         <= 1'b0;
      rate               <= '0;
      accum              <= '0;
      step               <= 1'b0;
      dir                <= 1'b0;
      encoder_count_last <= '0;
    end else begin
      step <= 1'b0;
      if (load) begin
        // Zero-length move is consumed without running
        busy       <= (move_duration != '0);
        ticks_left <= move_duration;
        first_tick <= 1'b1;
        div_cnt    <= '0;
        dir        <= move_dir;
      end else if (tick) begin
        div_cnt    <= '0;
        first_tick <= 1'b0;
        rate       <= rate_next;
        // Accumulator carries over between moves
        if (acc_sum > 0) begin
          step  <= 1'b1;
          accum <= acc_sum - DDA_THRESHOLD;
        end else begin
          accum <= acc_sum;
        end
        encoder_count_last <= encoder_count;
        ticks_left         <= ticks_left - 1'b1;
        if (ticks_left == 1) busy <= 1'b0;
      end else if (busy) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Move parameters held for the whole move
  always_ff @(posedge CLK) begin
    if (load) begin
      inc_r    <= move_increment;
      incinc_r <= move_incr_incr;
    end
  end

endmodule

/* verilog/hbridge_sequencer.sv */
`timescale 1ns/1ps

module hbridge_sequencer (
  input  logic CLK,
  input  logic reset,
  input  logic step,
  input  logic dir,
  input  logic half_step,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  // Position in the 8-state half-step table
  logic [2:0] index;
  logic [2:0] delta;

  // Full step skips the in-between states
  assign delta = half_step ? 3'd1 : 3'd2;

  always_ff @(posedge CLK) begin
    if (reset) begin
      index <= 3'd0;
    end else if (step) begin
      index <= dir ? index + delta : index - delta;
    end
  end

  // Order is {a1, a2, b1, b2}
  always_comb begin
    case (index)
      3'd0:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1000;
      3'd1:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1010;
      3'd2:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0010;
      3'd3:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0110;
      3'd4:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0100;
      3'd5:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0101;
      3'd6:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0001;
      default: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1001;
    endcase
  end

endmodule

/* verilog/move_buffer.sv */
`timescale 1ns/1ps

module move_buffer import stepper_pkg::*; (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     push_valid,
  output logic                     push_ready,
  input  logic                     push_dir,
  input  logic [WORD_W-1:0]        push_duration,
  input  logic signed [WORD_W-1:0] push_increment,
  input  logic signed [WORD_W-1:0] push_incr_incr,
  output logic                     move_valid,
  input  logic                     move_ready,
  output logic                     move_dir,
  output logic [WORD_W-1:0]        move_duration,
  output logic signed [WORD_W-1:0] move_increment,
  output logic signed [WORD_W-1:0] move_incr_incr
);

  // Storage, one record per slot
  logic                     mem_dir       [MOVE_DEPTH];
  logic [WORD_W-1:0]        mem_duration  [MOVE_DEPTH];
  logic signed [WORD_W-1:0] mem_increment [MOVE_DEPTH];
  logic signed [WORD_W-1:0] mem_incr_incr [MOVE_DEPTH];
  logic [MOVE_PTR_W-1:0]    wr_ptr;
  logic [MOVE_PTR_W-1:0]    rd_ptr;
  logic [MOVE_PTR_W:0]      count;
  logic                     push;
  logic                     pop;

  assign push_ready = (count != (MOVE_PTR_W+1)'(MOVE_DEPTH));
  assign move_valid = (count != '0);
  assign push       = push_valid & push_ready;
  assign pop        = move_valid & move_ready;

  // Head entry always presented
  assign move_dir       = mem_dir[rd_ptr];
  assign move_duration  = mem_duration[rd_ptr];
  assign move_increment = mem_increment[rd_ptr];
  assign move_incr_incr = mem_incr_incr[rd_ptr];

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally, depth is a power of two
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      mem_dir[wr_ptr]       <= push_dir;
      mem_duration[wr_ptr]  <= push_duration;
      mem_increment[wr_ptr] <= push_increment;
      mem_incr_incr[wr_ptr] <= push_incr_incr;
    end
  end

endmodule

/* verilog/quadrature_counter.sv */
`timescale 1ns/1ps

module quadrature_counter import stepper_pkg::*; (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     enc_a,
  input  logic                     enc_b,
  output logic signed [WORD_W-1:0] encoder_count
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  // Last decoded {a, b}
  logic [1:0] prev_ab;
  logic [1:0] cur_ab;

  assign cur_ab = {a_sync[1], b_sync[1]};

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_sync        <= '0;
      b_sync        <= '0;
      prev_ab       <= '0;
      encoder_count <= '0;
    end else begin
      a_sync  <= {a_sync[0], enc_a};
      b_sync  <= {b_sync[0], enc_b};
      prev_ab <= cur_ab;
      // A leading B counts up
      case ({prev_ab, cur_ab})
        4'b0010, 4'b1011, 4'b1101, 4'b0100: encoder_count <= encoder_count + 1;
        4'b0001, 4'b0111, 4'b1110, 4'b1000: encoder_count <= encoder_count - 1;
        // No change or both pins moved at once
        default: ;
      endcase
    end
  end

endmodule

/* verilog/spi_word_receiver.sv */
`timescale 1ns/1ps

module spi_word_receiver import stepper_pkg::*; (
  input  logic              CLK,
  input  logic              reset,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              copi,
  input  logic [WORD_W-1:0] reply_word,
  output logic              cipo,
  output logic              word_valid,
  output logic [WORD_W-1:0] word_data
);

  // Bit 0 newest, bit 2 kept for edge detection
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_rise;
  logic       cs_fall;
  logic       active;
  logic [WORD_W-1:0] rx_shift;
  logic [WORD_W-1:0] tx_shift;

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign cs_rise  = cs_sync[1] & ~cs_sync[2];
  assign cs_fall  = ~cs_sync[1] & cs_sync[2];
  assign active   = ~cs_sync[1];

  // MSB of the reply leads
  assign cipo = tx_shift[WORD_W-1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_sync   <= '0;
      cs_sync    <= '1;
      copi_sync  <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_sync   <= {sck_sync[1:0], sck};
      cs_sync    <= {cs_sync[1:0], cs_n};
      copi_sync  <= {copi_sync[0], copi};
      // One strobe per completed frame
      word_valid <= cs_rise;
    end
  end

  always_ff @(posedge CLK) begin
    // Reply captured at frame start, shifted on falling SCK
    if (cs_fall) begin
      tx_shift <= reply_word;
    end else if (active && sck_fall) begin
      tx_shift <= {tx_shift[WORD_W-2:0], 1'b0};
    end
    // COPI sampled on rising SCK, same sync delay as SCK
    if (active && sck_rise) begin
      rx_shift <= {rx_shift[WORD_W-2:0], copi_sync[1]};
    end
    if (cs_rise) begin
      word_data <= rx_shift;
    end
  end

endmodule

/* verilog/stepper_pkg.sv */
package stepper_pkg;

  // Bus and field widths
  localparam int WORD_W     = 64;
  localparam int DIV_W      = 24;
  localparam int MOVE_DEPTH = 4;
  localparam int MOVE_PTR_W = $clog2(MOVE_DEPTH);

  // Header opcodes, top byte of a header word
  localparam logic [7:0] OP_MOVE      = 8'h01;
  localparam logic [7:0] OP_DIVISOR   = 8'h03;
  localparam logic [7:0] OP_MICROSTEP = 8'h04;
  localparam logic [7:0] OP_VERSION   = 8'hfe;

  // Taken off the accumulator on every step
  localparam logic signed [WORD_W-1:0] DDA_THRESHOLD = 64'h7fffffffffffff9b;

  // API version reported on request
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd3;

  // 400 kHz DDA tick at 16 MHz
  localparam logic [DIV_W-1:0] DEFAULT_DIVISOR = 24'd40;

  // One SPI word, either a command header or a signed data value
  typedef union packed {
    struct packed {
      logic [7:0]  opcode;
      logic [55:0] payload;
    } hdr;
    logic signed [WORD_W-1:0] data;
  } cmd_word_u;

endpackage

/* verilog/stepper_top.sv */
`timescale 1ns/1ps

module stepper_top import stepper_pkg::*; (
  input  logic CLK,
  input  logic reset,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic step,
  output logic dir,
  output logic busy,
  output logic overflow
);

  // SPI word path
  logic              word_valid;
  logic [WORD_W-1:0] word_data;
  logic [WORD_W-1:0] reply_word;

  // Settings
  logic [DIV_W-1:0] clock_divisor;
  logic             half_step;

  // Decoder to buffer
  logic                     push_valid;
  logic                     push_ready;
  logic                     push_dir;
  logic [WORD_W-1:0]        push_duration;
  logic signed [WORD_W-1:0] push_increment;
  logic signed [WORD_W-1:0] push_incr_incr;

  // Buffer to step generator
  logic                     move_valid;
  logic                     move_ready;
  logic                     move_dir;
  logic [WORD_W-1:0]        move_duration;
  logic signed [WORD_W-1:0] move_increment;
  logic signed [WORD_W-1:0] move_incr_incr;

  // Encoder position, live and at last tick
  logic signed [WORD_W-1:0] encoder_count;
  logic signed [WORD_W-1:0] encoder_count_last;

  spi_word_receiver u_spi (
    .CLK(CLK), .reset(reset), .sck(sck), .cs_n(cs_n), .copi(copi),
    .reply_word(reply_word), .cipo(cipo),
    .word_valid(word_valid), .word_data(word_data)
  );

  command_decoder u_decoder (
    .CLK(CLK), .reset(reset), .word_valid(word_valid), .word_data(word_data),
    .encoder_count(encoder_count), .encoder_count_last(encoder_count_last),
    .reply_word(reply_word), .clock_divisor(clock_divisor), .half_step(half_step),
    .push_valid(push_valid), .push_dir(push_dir), .push_duration(push_duration),
    .push_increment(push_increment), .push_incr_incr(push_incr_incr),
    .push_ready(push_ready), .overflow(overflow)
  );

  move_buffer u_buffer (
    .CLK(CLK), .reset(reset),
    .push_valid(push_valid), .push_ready(push_ready), .push_dir(push_dir),
    .push_duration(push_duration), .push_increment(push_increment),
    .push_incr_incr(push_incr_incr),
    .move_valid(move_valid), .move_ready(move_ready), .move_dir(move_dir),
    .move_duration(move_duration), .move_increment(move_increment),
    .move_incr_incr(move_incr_incr)
  );

  dda_step_generator u_dda (
    .CLK(CLK), .reset(reset), .clock_divisor(clock_divisor),
    .move_valid(move_valid), .move_dir(move_dir), .move_duration(move_duration),
    .move_increment(move_increment), .move_incr_incr(move_incr_incr),
    .move_ready(move_ready), .step(step), .dir(dir), .busy(busy),
    .encoder_count(encoder_count), .encoder_count_last(encoder_count_last)
  );

  hbridge_sequencer u_hbridge (
    .CLK(CLK), .reset(reset), .step(step), .dir(dir), .half_step(half_step),
    .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  quadrature_counter u_encoder (
    .CLK(CLK), .reset(reset), .enc_a(enc_a), .enc_b(enc_b),
    .encoder_count(encoder_count)
  );

endmodule
